//--- Bender.yml
package:
  name: video

sources:
  - design/video_pkg.sv
  - design/byte_ram.sv
  - design/video_timing.sv
  - design/io_registers.sv
  - design/vram_slot_scheduler.sv
  - design/scan_line_buffer.sv
  - design/palette_lookup.sv
  - design/video_top.sv
  - target: simulation
    files:
      - verif/video_clock_gen.sv
      - verif/video_asserts.sv
      - verif/video_tb.sv

//--- all.f
design/video_pkg.sv
design/byte_ram.sv
design/video_timing.sv
design/io_registers.sv
design/vram_slot_scheduler.sv
design/scan_line_buffer.sv
design/palette_lookup.sv
design/video_top.sv
verif/video_clock_gen.sv
verif/video_asserts.sv
verif/video_tb.sv

//--- design/byte_ram.sv
module byte_ram #(
	parameter int DEPTH_AW = 8
) (
	input  logic                clk,
	input  logic [DEPTH_AW-1:0] address,
	input  logic                we,
	input  logic [7:0]          wdata,
	output logic [7:0]          rdata
);

	logic [7:0] mem [2**DEPTH_AW];

	// read returns the old word on a write
	always_ff @(posedge clk) begin
		if (we)
			mem[address] <= wdata;
		rdata <= mem[address];
	end

endmodule

//--- design/io_registers.sv
module io_registers (
	input  logic                   clk,
	input  logic                   reset_n,
	input  video_pkg::cpu_bus_t    cpu,
	input  logic                   pal_done,
	input  logic                   vram_done,
	output video_pkg::pal_write_t  pal_write,
	output video_pkg::vram_write_t vram_write
);
	import video_pkg::*;

	logic       iorq_n_d;
	logic       wr_n_d;
	logic       wr_strobe;
	logic       sel_pal_index;
	logic       sel_pal_data;
	logic       sel_vram_addr;
	logic       sel_vram_data;
	pixel_t     pal_index;
	logic [1:0] pal_element;
	logic [7:0] stage_r;
	logic [7:0] stage_g;
	logic       pal_pending;
	pixel_t     req_index;
	rgb_t       req_color;
	logic [1:0] addr_phase;
	vram_addr_t vram_address;
	logic       data_pending;
	logic [7:0] data_wdata;

	// --------------------------------------------------
	// write strobe
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			iorq_n_d <= 1'b1;
			wr_n_d <= 1'b1;
		end else begin
			iorq_n_d <= cpu.iorq_n;
			wr_n_d <= cpu.wr_n;
		end
	end

	// rising wr_n with iorq_n low the clock before
	assign wr_strobe = !iorq_n_d && !wr_n_d && cpu.wr_n;
	assign sel_pal_index = wr_strobe && (cpu.address == PORT_PAL_INDEX);
	assign sel_pal_data = wr_strobe && (cpu.address == PORT_PAL_DATA);
	assign sel_vram_addr = wr_strobe && (cpu.address == PORT_VRAM_ADDR);
	assign sel_vram_data = wr_strobe && (cpu.address == PORT_VRAM_DATA);

	// --------------------------------------------------
	// palette port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pal_index <= '0;
			pal_element <= 2'd0;
		end else if (sel_pal_index) begin
			pal_index <= cpu.wdata;
			pal_element <= 2'd0;
		end else if (sel_pal_data) begin
			// blue closes the entry, move on to the next index
			if (pal_element == 2'd2) begin
				pal_index <= pal_index + 8'd1;
				pal_element <= 2'd0;
			end else begin
				pal_element <= pal_element + 2'd1;
			end
		end
	end

	// r and g wait here until blue arrives
	always_ff @(posedge clk) begin
		if (sel_pal_data) begin
			case (pal_element)
				2'd0: stage_r <= cpu.wdata;
				2'd1: stage_g <= cpu.wdata;
				default: begin
					req_index <= pal_index;
					req_color <= '{r: stage_r, g: stage_g, b: cpu.wdata};
				end
			endcase
		end
	end

	// a new entry overrides the done pulse
	always_ff @(posedge clk) begin
		if (!reset_n)
			pal_pending <= 1'b0;
		else if (sel_pal_data && pal_element == 2'd2)
			pal_pending <= 1'b1;
		else if (pal_done)
			pal_pending <= 1'b0;
	end

	assign pal_write = '{pending: pal_pending, index: req_index, color: req_color};

	// --------------------------------------------------
	// vram port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			vram_address <= '0;
			addr_phase <= 2'd0;
		end else if (vram_done) begin
			// post increment after each issued write
			vram_address <= vram_address + vram_addr_t'(1);
		end else if (sel_vram_addr) begin
			// low, middle, then high byte
			case (addr_phase)
				2'd0: vram_address[7:0] <= cpu.wdata;
				2'd1: vram_address[15:8] <= cpu.wdata;
				default: vram_address[VRAM_AW-1:16] <= cpu.wdata[VRAM_AW-17:0];
			endcase
			addr_phase <= (addr_phase == 2'd2) ? 2'd0 : addr_phase + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_vram_data)
			data_wdata <= cpu.wdata;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			data_pending <= 1'b0;
		else if (sel_vram_data)
			data_pending <= 1'b1;
		else if (vram_done)
			data_pending <= 1'b0;
	end

	assign vram_write = '{pending: data_pending, address: vram_address, wdata: data_wdata};

endmodule

//--- design/palette_lookup.sv
module palette_lookup (
	input  logic                  clk,
	input  logic                  reset_n,
	input  video_pkg::raster_t    raster,
	input  video_pkg::pixel_t     pixel,
	input  video_pkg::pal_write_t pal_write,
	output logic                  pal_done,
	output video_pkg::rgb_t       video
);
	import video_pkg::*;

	logic              odd;
	logic [PAL_AW-1:0] pal_addr;
	logic [2:0][7:0]   plane_wdata;
	logic [2:0][7:0]   plane_rdata;
	rgb_t              color;

	assign odd = raster.h_count[0];
	// even clock looks up the pixel, odd clock belongs to the cpu
	assign pal_addr = odd ? pal_write.index : pixel;
	assign pal_done = odd && pal_write.pending;
	// r in plane 2 down to b in plane 0
	assign plane_wdata = pal_write.color;

	for (genvar i = 0; i < 3; i++) begin : g_plane
		byte_ram #(
			.DEPTH_AW(PAL_AW)
		) u_plane_ram (
			.clk    (clk),
			.address(pal_addr),
			.we     (pal_done),
			.wdata  (plane_wdata[i]),
			.rdata  (plane_rdata[i])
		);
	end

	// odd clock holds the result of the even lookup
	always_ff @(posedge clk) begin
		if (!reset_n)
			color <= '0;
		else if (odd)
			color <= (raster.h_window && raster.v_window) ? rgb_t'(plane_rdata) : '0;
	end

	assign video = color;

endmodule

//--- design/scan_line_buffer.sv
module scan_line_buffer (
	input  logic               clk,
	input  logic               reset_n,
	input  video_pkg::raster_t raster,
	input  video_pkg::fill_t   fill,
	output video_pkg::pixel_t  pixel
);
	import video_pkg::*;

	count_t             vrel;
	count_t             pix_pos;
	logic               wr_sel;
	logic [LINE_AW-1:0] wr_count;
	logic [LINE_AW-1:0] rd_addr;
	logic [LINE_AW-1:0] buf_addr [2];
	logic               buf_we [2];
	pixel_t             buf_rdata [2];

	// same line pair numbering as the fetch side
	assign vrel = raster.v_count - count_t'(V_SYNC + V_BPORCH - 2);
	assign wr_sel = vrel[1];

	// line ram, palette ram and colour register ahead of de
	assign pix_pos = raster.h_count - count_t'(H_SYNC + H_BPORCH - 3);
	// two clocks per pixel
	assign rd_addr = pix_pos[LINE_AW:1];

	// counts captured bytes over both lines of the pair
	always_ff @(posedge clk) begin
		if (!reset_n)
			wr_count <= '0;
		else if (raster.line_end && vrel[0])
			wr_count <= '0;
		else if (fill.valid)
			wr_count <= wr_count + LINE_AW'(1);
	end

	// --------------------------------------------------
	// ping-pong line rams
	// --------------------------------------------------
	for (genvar i = 0; i < 2; i++) begin : g_line
		assign buf_addr[i] = (wr_sel == 1'(i)) ? wr_count : rd_addr;
		assign buf_we[i] = fill.valid && (wr_sel == 1'(i));

		byte_ram #(
			.DEPTH_AW(LINE_AW)
		) u_line_ram (
			.clk    (clk),
			.address(buf_addr[i]),
			.we     (buf_we[i]),
			.wdata  (fill.data),
			.rdata  (buf_rdata[i])
		);
	end

	// show the buffer that is not being filled
	assign pixel = wr_sel ? buf_rdata[0] : buf_rdata[1];

endmodule

//--- design/video_pkg.sv
package video_pkg;

	// basic value types
	typedef logic [11:0] count_t;
	typedef logic [7:0] pixel_t;

	// --------------------------------------------------
	// 1280x720 raster timing
	// --------------------------------------------------
	localparam count_t H_TOTAL = 12'd1650;
	localparam count_t H_SYNC = 12'd40;
	localparam count_t H_BPORCH = 12'd220;
	localparam count_t H_RES = 12'd1280;
	localparam count_t V_TOTAL = 12'd750;
	localparam count_t V_SYNC = 12'd5;
	localparam count_t V_BPORCH = 12'd20;
	localparam count_t V_RES = 12'd720;

	// cpu i/o ports
	localparam logic [7:0] PORT_PAL_INDEX = 8'h20;
	localparam logic [7:0] PORT_PAL_DATA = 8'h21;
	localparam logic [7:0] PORT_VRAM_ADDR = 8'h22;
	localparam logic [7:0] PORT_VRAM_DATA = 8'h23;

	// widths
	localparam int VRAM_AW = 23;
	// 640 bytes per line
	localparam int LINE_AW = 10;
	localparam int PAL_AW = 8;
	// clocks per vram slot
	localparam int SLOT_LEN = 16;

	typedef logic [VRAM_AW-1:0] vram_addr_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		logic       iorq_n;
		logic       wr_n;
		logic [7:0] address;
		logic [7:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		count_t h_count;
		count_t v_count;
		logic   h_window;
		logic   v_window;
		logic   line_end;
	} raster_t;

	typedef struct packed {
		vram_addr_t address;
		logic       wr_n;
		logic       rd_n;
		logic       rfsh_n;
		logic [7:0] wdata;
	} vram_cmd_t;

	typedef struct packed {
		logic   pending;
		pixel_t index;
		rgb_t   color;
	} pal_write_t;

	typedef struct packed {
		logic       pending;
		vram_addr_t address;
		logic [7:0] wdata;
	} vram_write_t;

	// one captured byte on its way to the line buffer
	typedef struct packed {
		logic   valid;
		pixel_t data;
	} fill_t;

endpackage

//--- design/video_timing.sv
module video_timing (
	input  logic               clk,
	input  logic               reset_n,
	output video_pkg::raster_t raster,
	output logic               hs,
	output logic               vs,
	output logic               de
);
	import video_pkg::*;

	count_t     h_count;
	count_t     v_count;
	logic       h_window;
	logic       v_window;
	logic       line_end;
	logic       frame_end;
	logic [1:0] de_pipe;

	assign line_end = (h_count == H_TOTAL - 12'd1);
	assign frame_end = (v_count == V_TOTAL - 12'd1);

	// --------------------------------------------------
	// counters
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_count <= '0;
			v_count <= '0;
		end else if (line_end) begin
			h_count <= '0;
			// vertical count steps once per line
			v_count <= frame_end ? '0 : v_count + 12'd1;
		end else begin
			h_count <= h_count + 12'd1;
		end
	end

	// --------------------------------------------------
	// windows and syncs
	// --------------------------------------------------
	// h window runs 3 clocks ahead of the first visible pixel
	// line ram, palette ram and colour register sit behind it
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			h_window <= 1'b0;
			v_window <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
		end else begin
			if (h_count == H_SYNC + H_BPORCH - 12'd3)
				h_window <= 1'b1;
			else if (h_count == H_SYNC + H_BPORCH + H_RES - 12'd3)
				h_window <= 1'b0;
			// hsync for counts 0 to H_SYNC-1
			if (line_end)
				hs <= 1'b1;
			else if (h_count == H_SYNC - 12'd1)
				hs <= 1'b0;
			if (line_end) begin
				if (v_count == V_SYNC + V_BPORCH - 12'd1)
					v_window <= 1'b1;
				else if (v_count == V_SYNC + V_BPORCH + V_RES - 12'd1)
					v_window <= 1'b0;
				// vsync for lines 0 to V_SYNC-1
				if (frame_end)
					vs <= 1'b1;
				else if (v_count == V_SYNC - 12'd1)
					vs <= 1'b0;
			end
		end
	end

	// de trails the fetch window by 2 clocks
	always_ff @(posedge clk) begin
		if (!reset_n)
			de_pipe <= '0;
		else
			de_pipe <= {de_pipe[0], h_window & v_window};
	end

	assign de = de_pipe[1];

	assign raster = '{
		h_count:  h_count,
		v_count:  v_count,
		h_window: h_window,
		v_window: v_window,
		line_end: line_end
	};

endmodule

//--- design/video_top.sv
module video_top (
	input  logic                 clk,
	input  logic                 reset_n,
	input  video_pkg::cpu_bus_t  cpu,
	input  logic [31:0]          vram_rdata,
	output video_pkg::vram_cmd_t vram_cmd,
	output logic                 video_de,
	output logic                 video_hs,
	output logic                 video_vs,
	output video_pkg::rgb_t      video
);
	import video_pkg::*;

	raster_t     raster;
	pal_write_t  pal_write;
	logic        pal_done;
	vram_write_t vram_write;
	logic        vram_done;
	fill_t       fill;
	pixel_t      pixel;

	video_timing u_video_timing (
		.clk    (clk),
		.reset_n(reset_n),
		.raster (raster),
		.hs     (video_hs),
		.vs     (video_vs),
		.de     (video_de)
	);

	io_registers u_io_registers (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu       (cpu),
		.pal_done  (pal_done),
		.vram_done (vram_done),
		.pal_write (pal_write),
		.vram_write(vram_write)
	);

	vram_slot_scheduler u_vram_slot_scheduler (
		.clk       (clk),
		.reset_n   (reset_n),
		.raster    (raster),
		.vram_write(vram_write),
		.vram_rdata(vram_rdata),
		.vram_cmd  (vram_cmd),
		.vram_done (vram_done),
		.fill      (fill)
	);

	scan_line_buffer u_scan_line_buffer (
		.clk    (clk),
		.reset_n(reset_n),
		.raster (raster),
		.fill   (fill),
		.pixel  (pixel)
	);

	palette_lookup u_palette_lookup (
		.clk      (clk),
		.reset_n  (reset_n),
		.raster   (raster),
		.pixel    (pixel),
		.pal_write(pal_write),
		.pal_done (pal_done),
		.video    (video)
	);

endmodule

//--- design/vram_slot_scheduler.sv
module vram_slot_scheduler (
	input  logic                   clk,
	input  logic                   reset_n,
	input  video_pkg::raster_t     raster,
	input  video_pkg::vram_write_t vram_write,
	input  logic [31:0]            vram_rdata,
	output video_pkg::vram_cmd_t   vram_cmd,
	output logic                   vram_done,
	output video_pkg::fill_t       fill
);
	import video_pkg::*;

	logic [$clog2(SLOT_LEN)-1:0] slot_phase;
	count_t     hrel;
	count_t     vrel;
	logic [7:0] column;
	vram_addr_t rd_address;
	logic       rd_issue;
	logic       wr_slot;
	logic       wr_issue;
	vram_addr_t cmd_address;
	logic [7:0] cmd_wdata;
	logic       cmd_wr_n;
	logic       cmd_rd_n;
	logic       cmd_rfsh_n;
	logic [7:0] rd_pipe;
	logic [31:0] rd_word;
	logic [2:0] remain;
	logic       emit;

	// slots are aligned to multiples of 16 in the line
	assign slot_phase = raster.h_count[$clog2(SLOT_LEN)-1:0];
	// fetch starts one slot before the visible window
	assign hrel = raster.h_count - count_t'(H_SYNC + H_BPORCH - SLOT_LEN);
	// fetch runs one line pair ahead of display
	assign vrel = raster.v_count - count_t'(V_SYNC + V_BPORCH - 2);

	// second line of the pair fetches the upper half of the row
	assign column = 8'(hrel[10:4]) + (vrel[0] ? 8'(H_RES / SLOT_LEN) : 8'd0);
	// row stride of 256 words
	assign rd_address = vram_addr_t'({vrel[9:1], column});

	// read lands in phase 1, write or refresh in phase 9
	assign rd_issue = (slot_phase == '0) && (hrel < H_RES) && (vrel < V_RES);
	assign wr_slot = (int'(slot_phase) == SLOT_LEN / 2);
	assign wr_issue = wr_slot && vram_write.pending;

	// --------------------------------------------------
	// command register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cmd_wr_n <= 1'b1;
			cmd_rd_n <= 1'b1;
			cmd_rfsh_n <= 1'b1;
			vram_done <= 1'b0;
		end else begin
			cmd_rd_n <= !rd_issue;
			cmd_wr_n <= !wr_issue;
			// idle slot gets a refresh
			cmd_rfsh_n <= !(wr_slot && !vram_write.pending);
			vram_done <= wr_issue;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_issue)
			cmd_address <= rd_address;
		else if (wr_issue)
			cmd_address <= vram_write.address;
		if (wr_issue)
			cmd_wdata <= vram_write.wdata;
	end

	assign vram_cmd = '{address: cmd_address, wr_n: cmd_wr_n, rd_n: cmd_rd_n,
		rfsh_n: cmd_rfsh_n, wdata: cmd_wdata};

	// --------------------------------------------------
	// read capture
	// --------------------------------------------------
	// bit 7 marks the eighth clock after rd_n low
	always_ff @(posedge clk) begin
		if (!reset_n)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[6:0], !cmd_rd_n};
	end

	// bytes go out on even counts, lsb first
	assign emit = (remain != 3'd0) && !raster.h_count[0];

	always_ff @(posedge clk) begin
		if (rd_pipe[7])
			rd_word <= vram_rdata;
		else if (emit)
			rd_word <= rd_word >> 8;
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			remain <= 3'd0;
		else if (rd_pipe[7])
			remain <= 3'd4;
		else if (emit)
			remain <= remain - 3'd1;
	end

	assign fill = '{valid: emit, data: rd_word[7:0]};

endmodule

//--- verif/video_asserts.sv
module video_asserts (
	input logic                 clk,
	input logic                 reset_n,
	input video_pkg::vram_cmd_t vram_cmd,
	input video_pkg::fill_t     fill
);
	import video_pkg::*;

	logic [3:0] fill_count;
	logic       seen_read;
	logic [4:0] cmd_gap;

	// bytes delivered since the last read strobe
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			fill_count <= '0;
			seen_read <= 1'b0;
		end else if (!vram_cmd.rd_n) begin
			fill_count <= '0;
			seen_read <= 1'b1;
		end else if (fill.valid) begin
			fill_count <= fill_count + 4'd1;
		end
	end

	// clocks since the last write or refresh, saturates at one slot
	always_ff @(posedge clk) begin
		if (!reset_n)
			cmd_gap <= 5'(SLOT_LEN);
		else if (!vram_cmd.wr_n || !vram_cmd.rfsh_n)
			cmd_gap <= 5'd1;
		else if (cmd_gap != 5'(SLOT_LEN))
			cmd_gap <= cmd_gap + 5'd1;
	end

	// --------------------------------------------------
	// command strobes
	// --------------------------------------------------
	// never two commands at once
	a_one_cmd: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0({!vram_cmd.wr_n, !vram_cmd.rd_n, !vram_cmd.rfsh_n}))
		else $error("more than one vram command strobe low");

	// write or refresh at most once per slot
	a_one_per_slot: assert property (@(posedge clk) disable iff (!reset_n)
		(!vram_cmd.wr_n || !vram_cmd.rfsh_n) |-> cmd_gap == 5'(SLOT_LEN))
		else $error("write or refresh strobes closer than one slot");

	// each strobe is a single clock
	a_wr_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		!vram_cmd.wr_n |=> vram_cmd.wr_n)
		else $error("wr_n low for more than one cycle");
	a_rd_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		!vram_cmd.rd_n |=> vram_cmd.rd_n)
		else $error("rd_n low for more than one cycle");
	a_rfsh_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		!vram_cmd.rfsh_n |=> vram_cmd.rfsh_n)
		else $error("rfsh_n low for more than one cycle");

	// previous read must have produced four bytes
	a_four_bytes: assert property (@(posedge clk) disable iff (!reset_n)
		(!vram_cmd.rd_n && seen_read) |-> fill_count == 4'd4)
		else $error("read did not produce four fill bytes");

endmodule

bind vram_slot_scheduler video_asserts asserts_i (
	.clk     (clk),
	.reset_n (reset_n),
	.vram_cmd(vram_cmd),
	.fill    (fill)
);

//--- verif/video_clock_gen.sv
module video_clock_gen (
	output logic clk,
	output logic reset_n
);

	// 4 unit period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held for two cycles, released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
	end

endmodule

//--- verif/video_tb.sv
module video_tb;
	import video_pkg::*;

	localparam int FRAME_CYCLES = 1650 * 750;
	// timing frame, palette frame, display frame and the frame after reset
	localparam int WATCHDOG_TIME = 4 * FRAME_CYCLES * 4;

	logic        clk;
	logic        reset_n;
	cpu_bus_t    cpu;
	logic [31:0] vram_rdata;
	vram_cmd_t   vram_cmd;
	logic        video_de;
	logic        video_hs;
	logic        video_vs;
	rgb_t        video;

	// vram model and observed write commands
	logic [31:0] vram_mem [vram_addr_t];
	vram_cmd_t   wr_queue [$];
	time         wr_times [$];
	int          rfsh_count;
	// palette model
	rgb_t        pal_model [256];
	pixel_t      pal_list [$];

	video_clock_gen clock_gen_i (
		.clk    (clk),
		.reset_n(reset_n)
	);

	video_top video_top_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.cpu       (cpu),
		.vram_rdata(vram_rdata),
		.vram_cmd  (vram_cmd),
		.video_de  (video_de),
		.video_hs  (video_hs),
		.video_vs  (video_vs),
		.video     (video)
	);

	// --------------------------------------------------
	// error reporting and compares
	// --------------------------------------------------
	task automatic report_failure(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_count(input count_t actual, input count_t expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %0d, expected %0d", what, actual, expected));
	endtask

	task automatic check_vram_cmd(input vram_cmd_t actual, input vram_cmd_t expected);
		if (actual !== expected)
			report_failure($sformatf("vram command: got %h, expected %h", actual, expected));
	endtask

	task automatic check_rgb(input rgb_t actual, input rgb_t expected, input string what);
		if (actual !== expected)
			report_failure($sformatf("%s: got %h, expected %h", what, actual, expected));
	endtask

	// --------------------------------------------------
	// vram model
	// --------------------------------------------------
	function automatic logic [31:0] vram_lookup(input vram_addr_t address);
		if (vram_mem.exists(address))
			return vram_mem[address];
		return 32'h0;
	endfunction

	// memory side sampled and driven on the falling edge
	always @(negedge clk) begin
		if (reset_n) begin
			if (!vram_cmd.rd_n)
				vram_rdata <= vram_lookup(vram_cmd.address);
			if (!vram_cmd.wr_n && !vram_cmd.rfsh_n)
				report_failure("write and refresh issued in the same cycle");
			if (!vram_cmd.wr_n) begin
				// byte write lands in lane 0
				vram_mem[vram_cmd.address] = {24'h0, vram_cmd.wdata};
				wr_queue.push_back(vram_cmd);
				wr_times.push_back($time);
			end
			if (!vram_cmd.rfsh_n)
				rfsh_count++;
		end
	end

	// one cpu i/o write cycle
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(negedge clk);
		cpu.iorq_n = 1'b0;
		cpu.wr_n = 1'b0;
		cpu.address = port;
		cpu.wdata = data;
		@(negedge clk);
		cpu.iorq_n = 1'b1;
		cpu.wr_n = 1'b1;
		@(negedge clk);
	endtask

	// colour for visible line y, pixel x
	function automatic rgb_t expected_color(input int y, input int x);
		logic [31:0] word;
		pixel_t      index;
		word = vram_lookup(vram_addr_t'((y / 2) * 256 + x / 4));
		index = word[8 * (x % 4) +: 8];
		return pal_model[index];
	endfunction

	// rows 0 and 1 hold the first four visible lines
	task automatic fill_rows(input bit random_pick);
		vram_addr_t  address;
		logic [31:0] word;
		int          k;
		for (int row = 0; row < 2; row++) begin
			for (int col = 0; col < 160; col++) begin
				address = vram_addr_t'(row * 256 + col);
				for (int b = 0; b < 4; b++) begin
					if (random_pick)
						k = $urandom_range(pal_list.size() - 1, 0);
					else
						k = ((address * 7) ^ (address >> 3) + b * 5) % pal_list.size();
					word[8 * b +: 8] = pal_list[k];
				end
				vram_mem[address] = word;
			end
		end
	endtask

	// pixels counted from de in pairs of clocks
	task automatic check_lines(input int count, input string name);
		int line;
		int col;
		line = 0;
		col = 0;
		while (line < count) begin
			@(negedge clk);
			if (video_de) begin
				check_rgb(video, expected_color(line, col / 2),
					$sformatf("%s line %0d pixel %0d", name, line, col / 2));
				col++;
			end else if (col != 0) begin
				check_count(count_t'(col), 12'd1280, $sformatf("%s de length", name));
				line++;
				col = 0;
			end
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_vram_write();
		vram_addr_t base;
		logic [7:0] data;
		vram_cmd_t  expected;
		int         wait_cycles;
		// idle slots get a refresh each
		@(negedge clk);
		rfsh_count = 0;
		repeat (8 * SLOT_LEN) @(negedge clk);
		check_count(count_t'(rfsh_count), 12'd8, "idle refresh count");
		for (int round = 0; round < 2; round++) begin
			base = vram_addr_t'($urandom);
			io_write(PORT_VRAM_ADDR, base[7:0]);
			io_write(PORT_VRAM_ADDR, base[15:8]);
			io_write(PORT_VRAM_ADDR, {1'b0, base[22:16]});
			wr_queue.delete();
			wr_times.delete();
			for (int k = 0; k < 4; k++) begin
				data = 8'($urandom);
				io_write(PORT_VRAM_DATA, data);
				wait_cycles = 0;
				while (wr_queue.size() == 0) begin
					@(negedge clk);
					wait_cycles++;
					if (wait_cycles > 4 * SLOT_LEN)
						report_failure("no vram write issued after cpu data write");
				end
				expected = '{address: base + vram_addr_t'(k), wr_n: 1'b0, rd_n: 1'b1,
					rfsh_n: 1'b1, wdata: data};
				check_vram_cmd(wr_queue.pop_front(), expected);
				if (k > 0 && wr_times[k] - wr_times[k - 1] < 4 * SLOT_LEN)
					report_failure("two vram writes within one slot");
			end
			// long enough for a stray write to reach its slot
			repeat (2 * SLOT_LEN) @(negedge clk);
			check_count(count_t'(wr_queue.size()), 12'd0, "extra vram writes");
		end
	endtask

	task automatic test_timing();
		count_t hs_cnt;
		count_t de_cnt;
		int     de_first;
		@(negedge clk);
		while (video_vs !== 1'b1)
			@(negedge clk);
		// line 0 of a frame starts here
		for (int line = 0; line < 750; line++) begin
			hs_cnt = '0;
			de_cnt = '0;
			de_first = -1;
			check_count(count_t'(video_vs), count_t'(line < 5), $sformatf("vs on line %0d", line));
			for (int h = 0; h < 1650; h++) begin
				if (video_hs)
					hs_cnt++;
				if (video_de) begin
					if (de_first < 0)
						de_first = h;
					de_cnt++;
				end
				@(negedge clk);
			end
			check_count(hs_cnt, 12'd40, $sformatf("hs length line %0d", line));
			if (line >= 25 && line < 745) begin
				check_count(de_cnt, 12'd1280, $sformatf("de length line %0d", line));
				check_count(count_t'(de_first), 12'd260, $sformatf("de start line %0d", line));
			end else begin
				check_count(de_cnt, 12'd0, $sformatf("de outside frame line %0d", line));
			end
		end
	endtask

	task automatic test_palette();
		pixel_t index;
		rgb_t   color;
		pal_list.delete();
		// two entries through one index write
		index = 8'($urandom);
		io_write(PORT_PAL_INDEX, index);
		for (int e = 0; e < 2; e++) begin
			color = rgb_t'($urandom);
			io_write(PORT_PAL_DATA, color.r);
			io_write(PORT_PAL_DATA, color.g);
			io_write(PORT_PAL_DATA, color.b);
			pal_model[index + pixel_t'(e)] = color;
			pal_list.push_back(index + pixel_t'(e));
		end
		for (int e = 0; e < 6; e++) begin
			index = 8'($urandom);
			color = rgb_t'($urandom);
			io_write(PORT_PAL_INDEX, index);
			io_write(PORT_PAL_DATA, color.r);
			io_write(PORT_PAL_DATA, color.g);
			io_write(PORT_PAL_DATA, color.b);
			pal_model[index] = color;
			pal_list.push_back(index);
		end
		repeat (4) @(negedge clk);
		fill_rows(1'b1);
		check_lines(4, "palette");
	endtask

	task automatic test_display();
		@(posedge video_vs);
		fill_rows(1'b0);
		check_lines(4, "display");
	endtask

	// --------------------------------------------------
	// run
	// --------------------------------------------------
	initial begin
		cpu = '{iorq_n: 1'b1, wr_n: 1'b1, address: 8'h00, wdata: 8'h00};
		vram_rdata = 32'h0;
		rfsh_count = 0;
		void'($urandom(32'h1f927de5));
		wait (reset_n === 1'b1);
		test_vram_write();
		test_timing();
		test_palette();
		test_display();
		$display("TEST RESULT: PASS");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish in the allowed time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule
